/* src/fetchPkg.sv */
`default_nettype none

package fetchPkg;

  localparam int dataWidth     = 16;                // data word and pc width
  localparam int imemDepth     = 256;               // instruction words
  localparam int imemAddrWidth = $clog2(imemDepth); // 8 bits of word index

  // control-flow opcodes, everything else just steps the pc
  localparam logic [3:0] opB   = 4'b1100;  // branch on cond, pc-relative imm
  localparam logic [3:0] opBr  = 4'b1101;  // branch on cond to register value
  localparam logic [3:0] opPcs = 4'b1110;  // pc save, fetch side only steps
  localparam logic [3:0] opHlt = 4'b1111;  // stop fetching

  localparam logic [2:0] condNe     = 3'b000;
  localparam logic [2:0] condEq     = 3'b001;
  localparam logic [2:0] condGt     = 3'b010;
  localparam logic [2:0] condLt     = 3'b011;
  localparam logic [2:0] condGe     = 3'b100;
  localparam logic [2:0] condLe     = 3'b101;
  localparam logic [2:0] condOvf    = 3'b110;
  localparam logic [2:0] condAlways = 3'b111;

  typedef logic [2:0] flagVec;  // {N, V, Z}

  typedef struct packed {
    logic [3:0] op;
    logic [2:0] cond;
    logic [8:0] offset;  // signed, in words
  } immFmt;

  typedef struct packed {
    logic [3:0] op;
    logic [2:0] cond;
    logic [3:0] rs;      // target register, read by regfile side
    logic [4:0] unused;
  } regFmt;

  // same 16 bits seen as B format or BR format
  typedef union packed {
    immFmt imm;
    regFmt regForm;
  } instrWord;

endpackage

`default_nettype wire

/* src/claAdder16.sv */
`timescale 1ns/1ps
`default_nettype none

module claAdder16 (
  input  logic [15:0] a,
  input  logic [15:0] b,
  output logic [15:0] sum,
  output logic        carryOut
);

  logic [4:0] groupCarry;  // carry into each 4-bit group, [4] is the msb carry

  assign groupCarry[0] = 1'b0;  // no carry-in on this adder

  for (genvar g = 0; g < 4; g++) begin : genGroup
    logic [3:0] grpGen;   // bit generate
    logic [3:0] grpProp;  // bit propagate
    logic [4:0] c;        // lookahead carries inside the group

    assign grpGen  = a[4*g +: 4] & b[4*g +: 4];
    assign grpProp = a[4*g +: 4] ^ b[4*g +: 4];

    assign c[0] = groupCarry[g];  // rippled in from lower group
    assign c[1] = grpGen[0] | (grpProp[0] & c[0]);
    assign c[2] = grpGen[1] | (grpProp[1] & grpGen[0]) | (grpProp[1] & grpProp[0] & c[0]);
    assign c[3] = grpGen[2] | (grpProp[2] & grpGen[1])
                | (grpProp[2] & grpProp[1] & grpGen[0])
                | (grpProp[2] & grpProp[1] & grpProp[0] & c[0]);
    assign c[4] = grpGen[3] | (grpProp[3] & grpGen[2])
                | (grpProp[3] & grpProp[2] & grpGen[1])
                | (grpProp[3] & grpProp[2] & grpProp[1] & grpGen[0])
                | (grpProp[3] & grpProp[2] & grpProp[1] & grpProp[0] & c[0]);

    assign sum[4*g +: 4]   = grpProp ^ c[3:0];
    assign groupCarry[g+1] = c[4];  // ripple to next group
  end

  assign carryOut = groupCarry[4];

endmodule

`default_nettype wire

/* src/pcControl.sv */
`timescale 1ns/1ps
`default_nettype none

module pcControl (
  input  logic [fetchPkg::dataWidth-1:0] pc,
  input  fetchPkg::instrWord             instr,
  input  fetchPkg::flagVec               flags,
  input  logic [fetchPkg::dataWidth-1:0] regData,
  output logic [fetchPkg::dataWidth-1:0] pcNext,
  output logic                           branchTaken,
  output logic                           haltOp
);

  import fetchPkg::*;

  logic [dataWidth-1:0] pcPlus2;       // sequential next pc
  logic [dataWidth-1:0] branchTarget;  // pc+2 + offset*2
  logic [dataWidth-1:0] offsetShift;   // sign extended word offset in bytes
  logic [3:0]           op;
  logic [2:0]           cond;
  logic                 condMet;
  logic                 flagN, flagV, flagZ;

  assign op   = instr.imm.op;    // op sits at the same bits in both formats
  assign cond = instr.imm.cond;  // cond also shares its bits across both formats

  assign {flagN, flagV, flagZ} = flags;

  assign offsetShift = {{(dataWidth-10){instr.imm.offset[8]}}, instr.imm.offset, 1'b0};

  claAdder16 pcIncAdder (
    .a       (pc),
    .b       (dataWidth'(2)),
    .sum     (pcPlus2),
    .carryOut()                // pc wraps at 16 bits
  );

  claAdder16 branchAdder (
    .a       (pcPlus2),
    .b       (offsetShift),
    .sum     (branchTarget),
    .carryOut()
  );

  always_comb begin
    case (cond)
      condNe:     condMet = ~flagZ;
      condEq:     condMet = flagZ;
      condGt:     condMet = ~flagZ & ~flagN;
      condLt:     condMet = flagN;
      condGe:     condMet = flagZ | ~flagN;
      condLe:     condMet = flagN | flagZ;
      condOvf:    condMet = flagV;
      condAlways: condMet = 1'b1;
      default:    condMet = 1'b0;
    endcase
  end

  always_comb begin
    branchTaken = 1'b0;
    pcNext      = pcPlus2;  // default for every plain opcode and pcs
    case (op)
      opB: begin
        branchTaken = condMet;
        pcNext      = condMet ? branchTarget : pcPlus2;
      end
      opBr: begin
        branchTaken = condMet;
        pcNext      = condMet ? regData : pcPlus2;
      end
      opHlt:   pcNext = pc;  // hold on the hlt word
      default: pcNext = pcPlus2;
    endcase
  end

  assign haltOp = (op == opHlt);

endmodule

`default_nettype wire

/* src/flagRegister.sv */
`timescale 1ns/1ps
`default_nettype none

module flagRegister (
  input  logic             clk,
  input  logic             reset,
  input  logic             flagWrite,  // load strobe from execute side
  input  fetchPkg::flagVec flagIn,
  output fetchPkg::flagVec flags
);

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (flagWrite) begin
      flags <= flagIn;  // seen by branch logic next cycle
    end
  end

  // no strobe and no reset at the last edge means flags held
  assert property (@(posedge clk)
    (!$past(flagWrite) && !$past(reset)) |-> $stable(flags))
    else $error("flags changed without flagWrite");

endmodule

`default_nettype wire

/* src/instrMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module instrMemory (
  input  logic                               clk,
  input  logic                               imemWrite,
  input  logic [fetchPkg::imemAddrWidth-1:0] imemAddr,   // word address
  input  logic [fetchPkg::dataWidth-1:0]     imemData,
  input  logic [fetchPkg::dataWidth-1:0]     pc,         // byte address
  output fetchPkg::instrWord                 instr
);

  import fetchPkg::*;

  logic [dataWidth-1:0] memArray [imemDepth];  // plain regs, no reset

  always_ff @(posedge clk) begin
    if (imemWrite) begin
      memArray[imemAddr] <= imemData;  // one word per strobe cycle
    end
  end

  // async read, pc is byte addressed so drop bit 0
  assign instr = memArray[pc[imemAddrWidth:1]];

  // fetch must stay word aligned across every path that loads pc
  assert property (@(posedge clk) !$isunknown(pc) |-> (pc[0] == 1'b0))
    else $error("odd pc %h reached instruction memory", pc);

endmodule

`default_nettype wire

/* src/fetchSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchSequencer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           run,     // level, low stalls fetch
  input  logic [fetchPkg::dataWidth-1:0] pcNext,
  input  logic                           haltOp,
  output logic [fetchPkg::dataWidth-1:0] pc,
  output logic                           halted
);

  logic advance;  // an instruction retires this cycle

  assign advance = run && !halted;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (advance) begin
      pc <= pcNext;  // hlt feeds back its own address
      if (haltOp) begin
        halted <= 1'b1;  // sticky until reset
      end
    end
  end

  // once halted the pc is frozen
  assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc))
    else $error("pc moved while halted");

  // only reset may release the halt latch
  assert property (@(posedge clk) $fell(halted) |-> $past(reset))
    else $error("halted dropped without reset");

endmodule

`default_nettype wire

/* src/fetchTop.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchTop (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               imemWrite,
  input  logic [fetchPkg::imemAddrWidth-1:0] imemAddr,
  input  logic [fetchPkg::dataWidth-1:0]     imemData,
  input  logic                               flagWrite,
  input  fetchPkg::flagVec                   flagIn,
  input  logic [fetchPkg::dataWidth-1:0]     regData,  // BR target, combinational
  input  logic                               run,
  output logic [fetchPkg::dataWidth-1:0]     pc,
  output fetchPkg::instrWord                 instr,
  output logic                               branchTaken,
  output logic                               halted
);

  import fetchPkg::*;

  flagVec               flags;   // registered N V Z
  logic [dataWidth-1:0] pcNext;  // from branch logic to pc reg
  logic                 haltOp;

  instrMemory imem_i (
    .clk      (clk),
    .imemWrite(imemWrite),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .pc       (pc),
    .instr    (instr)
  );

  flagRegister flags_i (
    .clk      (clk),
    .reset    (reset),
    .flagWrite(flagWrite),
    .flagIn   (flagIn),
    .flags    (flags)
  );

  pcControl pcCtrl_i (
    .pc         (pc),
    .instr      (instr),
    .flags      (flags),
    .regData    (regData),
    .pcNext     (pcNext),
    .branchTaken(branchTaken),
    .haltOp     (haltOp)
  );

  fetchSequencer seq_i (
    .clk   (clk),
    .reset (reset),
    .run   (run),
    .pcNext(pcNext),
    .haltOp(haltOp),
    .pc    (pc),
    .halted(halted)
  );

endmodule

`default_nettype wire

/* dv/fetchTb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchTb;

  import fetchPkg::*;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        imemWrite = 1'b0;
  logic [7:0]  imemAddr = '0;
  logic [15:0] imemData = '0;
  logic        flagWrite = 1'b0;
  logic [2:0]  flagIn = '0;
  logic [15:0] regData = '0;
  logic        run = 1'b0;
  logic [15:0] pc;
  instrWord    instr;
  logic        branchTaken;
  logic        halted;

  logic [15:0] shadowMem [256];      // what the tb wrote into imem
  logic [15:0] modelPc = '0;
  logic        modelHalted = 1'b0;
  logic [2:0]  modelFlags = '0;      // {N, V, Z}
  logic [15:0] lfsrState = 16'h0001;
  logic        checkOn = 1'b0;

  fetchTop dut_i (
    .clk        (clk),
    .reset      (reset),
    .imemWrite  (imemWrite),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .flagWrite  (flagWrite),
    .flagIn     (flagIn),
    .regData    (regData),
    .run        (run),
    .pc         (pc),
    .instr      (instr),
    .branchTaken(branchTaken),
    .halted     (halted)
  );

  always #5 clk = ~clk;  // 10 ns period

  // taps 16 14 13 11 give maximal length
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic randBits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);  // one step per bit
      val = {val[14:0], lfsrState[0]};
    end
  endtask

  // returns {taken, next pc}
  function automatic logic [16:0] refNextPc(input logic [15:0] curPc, input logic [15:0] word,
                                            input logic [2:0] flg, input logic [15:0] rd);
    logic [3:0]  op;
    logic [2:0]  cond;
    logic        n, v, z, hit;
    logic [15:0] seqPc, target;
    op     = word[15:12];
    cond   = word[11:9];
    {n, v, z} = flg;
    seqPc  = curPc + 16'd2;                               // wraps at 16 bits
    target = seqPc + {{6{word[8]}}, word[8:0], 1'b0};     // signed word offset
    case (cond)
      condNe:  hit = !z;
      condEq:  hit = z;
      condGt:  hit = !z && !n;
      condLt:  hit = n;
      condGe:  hit = z || !n;
      condLe:  hit = n || z;
      condOvf: hit = v;
      default: hit = 1'b1;                                // always
    endcase
    if (op == opB) return {hit, hit ? target : seqPc};
    if (op == opBr) return {hit, hit ? rd : seqPc};
    if (op == opHlt) return {1'b0, curPc};
    return {1'b0, seqPc};                                 // pcs and plain ops
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // model state follows the same edges as the dut
  always @(posedge clk) begin : modelStep
    logic [16:0] stepVal;
    stepVal = refNextPc(modelPc, shadowMem[modelPc[8:1]], modelFlags, regData);
    if (imemWrite) shadowMem[imemAddr] <= imemData;   // imem has no reset
    if (reset) begin
      modelPc     <= '0;
      modelHalted <= 1'b0;
      modelFlags  <= '0;
    end else begin
      if (flagWrite) modelFlags <= flagIn;
      if (run && !modelHalted) begin
        modelPc <= stepVal[15:0];
        if (shadowMem[modelPc[8:1]][15:12] == opHlt) modelHalted <= 1'b1;
      end
    end
  end

  // outputs only move at rising edges so the falling edge is a quiet point
  always @(negedge clk) begin : compareOut
    logic [16:0] expVal;
    logic [15:0] expInstr;
    expVal   = refNextPc(modelPc, shadowMem[modelPc[8:1]], modelFlags, regData);
    expInstr = shadowMem[modelPc[8:1]];
    if (checkOn) begin
      assert (pc === modelPc)
        else failRun($sformatf("MISMATCH pc expected %h got %h", modelPc, pc));
      assert (instr === expInstr)
        else failRun($sformatf("MISMATCH instr expected %h got %h", expInstr, instr));
      assert (branchTaken === expVal[16])
        else failRun($sformatf("MISMATCH branchTaken expected %h got %h",
                               expVal[16], branchTaken));
      assert (halted === modelHalted)
        else failRun($sformatf("MISMATCH halted expected %h got %h", modelHalted, halted));
    end
  end

  // load one word at the current pc with fresh flags and retire it
  task automatic runOne(input logic [15:0] word, input logic [2:0] flg,
                        input logic [15:0] rd);
    @(negedge clk);
    imemWrite = 1'b1;
    imemAddr  = modelPc[8:1];
    imemData  = word;
    flagWrite = 1'b1;
    flagIn    = flg;
    run       = 1'b0;
    @(negedge clk);
    imemWrite = 1'b0;
    flagWrite = 1'b0;
    regData   = rd;
    run       = 1'b1;   // retires at the next rising edge
    @(negedge clk);
    run = 1'b0;
  endtask

  task automatic waitHalted(input int limit);
    int count;
    count = 0;
    while (halted !== 1'b1) begin
      if (count == limit) failRun("timeout: halted never rose after HLT was fetched");
      @(negedge clk);
      count++;
    end
  endtask

  initial begin
    logic [15:0] r, f, c, pick;
    logic [15:0] heldPc, haltPc;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    assert (pc === 16'h0000 && halted === 1'b0)
      else failRun($sformatf("MISMATCH pc/halted after reset got %h/%h", pc, halted));

    // fill imem with plain ops whose pattern uses every address bit
    for (int a = 0; a < 256; a++) begin
      @(negedge clk);
      imemWrite = 1'b1;
      imemAddr  = a[7:0];
      imemData  = {4'(a % 12), a[3:0], a[7:0]};
    end
    @(negedge clk);
    imemWrite = 1'b0;
    checkOn   = 1'b1;

    run = 1'b1;            // straight-line stepping
    repeat (30) @(negedge clk);
    run = 1'b0;
    assert (pc === 16'd60) else failRun($sformatf("MISMATCH pc expected %h got %h", 16'd60, pc));

    // wrap up through ffff and back down through zero
    runOne({opBr, condAlways, 9'h000}, 3'b000, 16'hfffc);
    runOne(16'h1234, 3'b000, 16'h0000);
    runOne(16'h2345, 3'b000, 16'h0000);
    runOne({opB, condAlways, 9'h1fe}, 3'b000, 16'h0000);

    for (int ci = 0; ci < 8; ci++) begin
      for (int fi = 0; fi < 8; fi++) begin
        randBits(9, r);
        randBits(15, f);
        runOne({opB, ci[2:0], r[8:0]}, fi[2:0], {f[14:0], 1'b0});
      end
    end

    for (int i = 0; i < 48; i++) begin
      randBits(1, pick);
      randBits(3, c);
      randBits(3, f);
      randBits(15, r);
      if (pick[0]) runOne({opBr, c[2:0], r[3:0], 5'd0}, f[2:0], {r[14:0], 1'b0});
      else runOne({opPcs, c[2:0], r[8:0]}, f[2:0], {r[14:0], 1'b0});
    end

    // flag strobe takes effect one cycle later
    @(negedge clk);
    imemWrite = 1'b1;
    imemAddr  = modelPc[8:1];
    imemData  = {opB, condEq, 9'd5};
    flagWrite = 1'b1;
    flagIn    = 3'b000;
    @(negedge clk);
    imemWrite = 1'b0;
    flagIn    = 3'b001;  // Z set and loaded at the next edge
    #1;                  // settle before sampling, edge still ahead
    assert (branchTaken === 1'b0)
      else failRun($sformatf("MISMATCH branchTaken expected %h got %h", 1'b0, branchTaken));
    @(negedge clk);
    flagWrite = 1'b0;
    flagIn    = 3'b000;  // ignored without a strobe
    run       = 1'b1;
    #1;
    assert (branchTaken === 1'b1)
      else failRun($sformatf("MISMATCH branchTaken expected %h got %h", 1'b1, branchTaken));
    @(negedge clk);
    run       = 1'b0;
    imemWrite = 1'b1;
    imemAddr  = modelPc[8:1];
    imemData  = {opB, condNe, 9'd3};  // Z still set so not taken
    repeat (4) begin
      @(negedge clk);
      imemWrite = 1'b0;
      randBits(3, f);
      flagIn = f[2:0];
      assert (branchTaken === 1'b0)
        else failRun($sformatf("MISMATCH branchTaken expected %h got %h", 1'b0, branchTaken));
    end
    runOne({opPcs, 12'h000}, 3'b010, 16'h0000);

    // random stall stretches while whatever sits in imem keeps running
    for (int i = 0; i < 12; i++) begin
      randBits(3, r);
      heldPc = modelPc;
      run = 1'b0;
      repeat (r[2:0] + 1) @(negedge clk);
      assert (pc === heldPc)
        else failRun($sformatf("MISMATCH pc expected %h got %h", heldPc, pc));
      randBits(3, r);
      run = 1'b1;
      repeat (r[2:0] + 1) @(negedge clk);
    end
    run = 1'b0;

    @(negedge clk);
    imemWrite = 1'b1;
    imemAddr  = modelPc[8:1];
    imemData  = {opHlt, 12'h000};
    haltPc    = modelPc;
    @(negedge clk);
    imemWrite = 1'b0;
    run       = 1'b1;
    waitHalted(8);
    repeat (20) @(negedge clk);
    assert (pc === haltPc)
      else failRun($sformatf("MISMATCH pc expected %h got %h", haltPc, pc));

    reset = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    run   = 1'b0;
    @(negedge clk);
    assert (pc === 16'h0000 && halted === 1'b0)
      else failRun($sformatf("MISMATCH pc/halted after reset got %h/%h", pc, halted));

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
src/fetchPkg.sv
src/claAdder16.sv
src/pcControl.sv
src/flagRegister.sv
src/instrMemory.sv
src/fetchSequencer.sv
src/fetchTop.sv
dv/fetchTb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run fetchTb, search the log for the pass line"
	@echo "  clean  remove obj_dir and the log"

test:
	verilator --binary --timing --assert -f build.f --top-module fetchTb -o fetchSim
	./obj_dir/fetchSim | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
